//--- source/exec_pkg.sv
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int THREADS    = 4;
    localparam int ID_BITS    = $clog2(THREADS);
    localparam int SHAMT_BITS = $clog2(XLEN);

    typedef logic [XLEN-1:0]       rval_t;
    typedef logic [4:0]            ridx_t;
    typedef logic [ID_BITS-1:0]    id_t;
    typedef logic [31:0]           pc_t;
    typedef logic [31:0]           instr_t;
    typedef logic [SHAMT_BITS-1:0] shamt_t;

    // result source selected in stage 1 and stage 2
    typedef enum logic [2:0] {
        op_add   = 3'd0,
        op_logic = 3'd1,
        op_slt   = 3'd2,
        op_shift = 3'd3,
        op_pass  = 3'd4
    } alu_op_t;

    // low bits of funct3
    typedef enum logic [1:0] {
        lm_xor = 2'b00,
        lm_or  = 2'b10,
        lm_and = 2'b11
    } logic_mode_t;

    // funct3 for conditional branches, spare codes for jumps
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_jal  = 3'b010,
        br_jalr = 3'b011,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_mode_t;

    // ------------------------------
    // external records
    // ------------------------------
    typedef struct packed {
        id_t          id;
        pc_t          pc;
        instr_t       instr;
        logic         rd_en;
        ridx_t        rd_idx;
        rval_t        rd_val;
        rval_t        rs1_val;
        rval_t        rs2_val;
        alu_op_t      op;
        logic         sub;
        logic         imm_en;
        rval_t        imm_val;
        logic         slt_unsigned;
        logic_mode_t  logic_mode;
        logic         shift_left;
        logic         shift_arith;
        logic         branch;
        branch_mode_t branch_mode;
        pc_t          branch_pc;
    } issue_t;

    typedef struct packed {
        id_t    id;
        pc_t    pc;
        instr_t instr;
        logic   rd_en;
        ridx_t  rd_idx;
        rval_t  rd_val;
    } wb_t;

    typedef struct packed {
        id_t    id;
        pc_t    pc;
        pc_t    old_pc;
        instr_t instr;
    } branch_t;

    // ------------------------------
    // stage records
    // ------------------------------
    typedef struct packed {
        id_t          id;
        pc_t          pc;
        instr_t       instr;
        logic         rd_en;
        ridx_t        rd_idx;
        rval_t        rd_val;
        rval_t        rs1_val;
        alu_op_t      op;
        logic         slt_unsigned;
        logic         shift_left;
        logic         shift_arith;
        logic         shift_imm_en;
        shamt_t       imm_shamt;
        shamt_t       rs2_shamt;
        logic         branch;
        branch_mode_t branch_mode;
        pc_t          branch_pc;
        rval_t        add_val;
        logic         carry;
        logic         rs1_sign;
        logic         op2_sign;
        logic         eq;
        rval_t        logic_val;
    } st0_t;

    typedef struct packed {
        id_t     id;
        pc_t     pc;
        instr_t  instr;
        logic    rd_en;
        ridx_t   rd_idx;
        alu_op_t op;
        logic    slt_flag;
        rval_t   shift_val;
        rval_t   rd_val;
    } st1_t;

endpackage

//--- source/exec_stage0.sv
`timescale 1ns/1ps

module exec_stage0 (
    input  logic             clk,
    input  logic             reset,
    input  exec_pkg::issue_t s_issue,
    input  logic             s_valid,
    output exec_pkg::st0_t   m_st0,
    output logic             m_valid
);

    exec_pkg::issue_t        issue_q;
    logic                    valid_q;
    logic                    cmp_branch;
    logic                    sub_en;
    exec_pkg::rval_t         op2;
    exec_pkg::rval_t         op2_inv;
    logic [exec_pkg::XLEN:0] sum;
    exec_pkg::rval_t         logic_val;

    // ------------------------------
    // issue register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        issue_q <= s_issue;
    end

    // ------------------------------
    // adder
    // ------------------------------

    // conditional branches always compare rs1 with rs2
    assign cmp_branch = issue_q.branch
                     && issue_q.branch_mode != exec_pkg::br_jal
                     && issue_q.branch_mode != exec_pkg::br_jalr;

    // slt needs the difference, jumps need the plain sum
    assign sub_en = issue_q.branch ? cmp_branch
                  : (issue_q.sub || issue_q.op == exec_pkg::op_slt);

    assign op2 = (issue_q.imm_en && !cmp_branch) ? issue_q.imm_val : issue_q.rs2_val;
    assign op2_inv = sub_en ? ~op2 : op2;

    // carry out set means rs1 >= op2 unsigned when subtracting
    assign sum = {1'b0, issue_q.rs1_val}
               + {1'b0, op2_inv}
               + {{exec_pkg::XLEN{1'b0}}, sub_en};

    // ------------------------------
    // logical unit
    // ------------------------------
    always_comb begin
        case (issue_q.logic_mode)
            exec_pkg::lm_xor: logic_val = issue_q.rs1_val ^ op2;
            exec_pkg::lm_or:  logic_val = issue_q.rs1_val | op2;
            default:          logic_val = issue_q.rs1_val & op2;
        endcase
    end

    // forward results with the control later stages need
    always_comb begin
        m_st0.id           = issue_q.id;
        m_st0.pc           = issue_q.pc;
        m_st0.instr        = issue_q.instr;
        m_st0.rd_en        = issue_q.rd_en;
        m_st0.rd_idx       = issue_q.rd_idx;
        m_st0.rd_val       = issue_q.rd_val;
        m_st0.rs1_val      = issue_q.rs1_val;
        m_st0.op           = issue_q.op;
        m_st0.slt_unsigned = issue_q.slt_unsigned;
        m_st0.shift_left   = issue_q.shift_left;
        m_st0.shift_arith  = issue_q.shift_arith;
        m_st0.shift_imm_en = issue_q.imm_en;
        m_st0.imm_shamt    = issue_q.imm_val[exec_pkg::SHAMT_BITS-1:0];
        m_st0.rs2_shamt    = issue_q.rs2_val[exec_pkg::SHAMT_BITS-1:0];
        m_st0.branch       = issue_q.branch;
        m_st0.branch_mode  = issue_q.branch_mode;
        m_st0.branch_pc    = issue_q.branch_pc;
        m_st0.add_val      = sum[exec_pkg::XLEN-1:0];
        m_st0.carry        = sum[exec_pkg::XLEN];
        m_st0.rs1_sign     = issue_q.rs1_val[exec_pkg::XLEN-1];
        m_st0.op2_sign     = op2[exec_pkg::XLEN-1];
        m_st0.eq           = (issue_q.rs1_val == issue_q.rs2_val);
        m_st0.logic_val    = logic_val;
    end

    assign m_valid = valid_q;

endmodule

//--- source/exec_stage1.sv
`timescale 1ns/1ps

module exec_stage1 (
    input  logic              clk,
    input  logic              reset,
    input  exec_pkg::st0_t    s_st0,
    input  logic              s_valid,
    output exec_pkg::st1_t    m_st1,
    output logic              m_valid,
    output exec_pkg::branch_t branch,
    output logic              branch_valid
);

    exec_pkg::shamt_t shamt;
    exec_pkg::rval_t  shift_val;
    exec_pkg::rval_t  chosen_val;
    exec_pkg::pc_t    target;
    logic             lt_signed;
    logic             lt_unsigned;
    logic             taken;

    // ------------------------------
    // shifter
    // ------------------------------
    assign shamt = s_st0.shift_imm_en ? s_st0.imm_shamt : s_st0.rs2_shamt;

    always_comb begin
        if (s_st0.shift_left) begin
            shift_val = s_st0.rs1_val << shamt;
        end else if (s_st0.shift_arith) begin
            shift_val = $signed(s_st0.rs1_val) >>> shamt;
        end else begin
            shift_val = s_st0.rs1_val >> shamt;
        end
    end

    // ------------------------------
    // compare flags
    // ------------------------------

    // no borrow out of rs1 - op2
    assign lt_unsigned = !s_st0.carry;

    // differing signs decide directly, else the difference sign does
    assign lt_signed = (s_st0.rs1_sign != s_st0.op2_sign) ? s_st0.rs1_sign
                     : s_st0.add_val[exec_pkg::XLEN-1];

    always_comb begin
        case (s_st0.op)
            exec_pkg::op_add:   chosen_val = s_st0.add_val;
            exec_pkg::op_logic: chosen_val = s_st0.logic_val;
            default:            chosen_val = s_st0.rd_val;
        endcase
    end

    // ------------------------------
    // branch resolution
    // ------------------------------
    always_comb begin
        case (s_st0.branch_mode)
            exec_pkg::br_beq:  taken = s_st0.eq;
            exec_pkg::br_bne:  taken = !s_st0.eq;
            exec_pkg::br_blt:  taken = lt_signed;
            exec_pkg::br_bge:  taken = !lt_signed;
            exec_pkg::br_bltu: taken = lt_unsigned;
            exec_pkg::br_bgeu: taken = !lt_unsigned;
            default:           taken = 1'b1;
        endcase
    end

    // jalr target is rs1 + imm with bit 0 cleared
    assign target = (s_st0.branch_mode == exec_pkg::br_jalr)
                  ? {s_st0.add_val[exec_pkg::XLEN-1:1], 1'b0}
                  : s_st0.branch_pc;

    // ------------------------------
    // stage 1 register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid      <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            m_valid      <= s_valid;
            branch_valid <= s_valid && s_st0.branch && taken;
        end
    end

    always_ff @(posedge clk) begin
        m_st1.id        <= s_st0.id;
        m_st1.pc        <= s_st0.pc;
        m_st1.instr     <= s_st0.instr;
        m_st1.rd_en     <= s_st0.rd_en;
        m_st1.rd_idx    <= s_st0.rd_idx;
        m_st1.op        <= s_st0.op;
        m_st1.slt_flag  <= s_st0.slt_unsigned ? lt_unsigned : lt_signed;
        m_st1.shift_val <= shift_val;
        m_st1.rd_val    <= chosen_val;
        branch.id       <= s_st0.id;
        branch.pc       <= target;
        branch.old_pc   <= s_st0.pc;
        branch.instr    <= s_st0.instr;
    end

endmodule

//--- source/exec_stage2.sv
`timescale 1ns/1ps

module exec_stage2 (
    input  logic           clk,
    input  logic           reset,
    input  exec_pkg::st1_t s_st1,
    input  logic           s_valid,
    output exec_pkg::wb_t  wb,
    output logic           wb_valid
);

    exec_pkg::rval_t result;

    // ------------------------------
    // final result select
    // ------------------------------
    always_comb begin
        case (s_st1.op)
            exec_pkg::op_slt: begin
                result = {{(exec_pkg::XLEN-1){1'b0}}, s_st1.slt_flag};
            end
            exec_pkg::op_shift: begin
                result = s_st1.shift_val;
            end
            default: begin
                // add, logic and pass were settled in stage 1
                result = s_st1.rd_val;
            end
        endcase
    end

    // ------------------------------
    // write-back register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb.id     <= s_st1.id;
        wb.pc     <= s_st1.pc;
        wb.instr  <= s_st1.instr;
        wb.rd_en  <= s_st1.rd_en;
        wb.rd_idx <= s_st1.rd_idx;
        wb.rd_val <= result;
    end

endmodule

//--- source/exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic              clk,
    input  logic              reset,
    input  exec_pkg::issue_t  s_issue,
    input  logic              s_valid,
    output exec_pkg::wb_t     wb,
    output logic              wb_valid,
    output exec_pkg::branch_t branch,
    output logic              branch_valid
);

    exec_pkg::st0_t st0;
    logic           st0_valid;
    exec_pkg::st1_t st1;
    logic           st1_valid;

    // issue register, adder and logical unit
    exec_stage0 u_stage0 (
        .clk     (clk),
        .reset   (reset),
        .s_issue (s_issue),
        .s_valid (s_valid),
        .m_st0   (st0),
        .m_valid (st0_valid)
    );

    // shifter, slt and branch redirect
    exec_stage1 u_stage1 (
        .clk          (clk),
        .reset        (reset),
        .s_st0        (st0),
        .s_valid      (st0_valid),
        .m_st1        (st1),
        .m_valid      (st1_valid),
        .branch       (branch),
        .branch_valid (branch_valid)
    );

    // write-back
    exec_stage2 u_stage2 (
        .clk      (clk),
        .reset    (reset),
        .s_st1    (st1),
        .s_valid  (st1_valid),
        .wb       (wb),
        .wb_valid (wb_valid)
    );

endmodule

//--- bench/exec_assert.sv
`timescale 1ns/1ps

module exec_assert (
    input logic clk,
    input logic reset,
    input logic s_valid,
    input logic wb_valid,
    input logic branch_valid
);

    int fail_count = 0;

    // outputs stay low while reset is held
    quiet_in_reset: assert property (@(posedge clk) reset |=> !wb_valid && !branch_valid)
    else begin
        $error("wb_valid or branch_valid high during reset");
        fail_count++;
    end

    // and in the first cycle after release
    quiet_after_reset: assert property (@(posedge clk) $fell(reset) |=> !wb_valid && !branch_valid)
    else begin
        $error("wb_valid or branch_valid high in the cycle after reset");
        fail_count++;
    end

    // a redirect needs an instruction sampled one edge before its own register edge
    branch_has_source: assert property (@(posedge clk) disable iff (reset)
        branch_valid |-> $past(s_valid, 2))
    else begin
        $error("branch_valid without a valid instruction behind it");
        fail_count++;
    end

endmodule

//--- bench/exec_checker.sv
`timescale 1ns/1ps

module exec_checker (
    input logic              clk,
    input logic              reset,
    input exec_pkg::wb_t     wb,
    input logic              wb_valid,
    input exec_pkg::branch_t branch,
    input logic              branch_valid
);

    exec_pkg::wb_t     wb_q[$];
    exec_pkg::branch_t br_q[$];
    int                wb_due_q[$];
    int                br_due_q[$];
    int                edge_count = 0;
    int                wb_errors = 0;
    int                branch_errors = 0;

    // called just after a rising edge, while the instruction is driven
    task automatic expect_wb(input exec_pkg::wb_t w);
        wb_q.push_back(w);
        wb_due_q.push_back(edge_count + 3);
    endtask

    task automatic expect_branch(input exec_pkg::branch_t b);
        br_q.push_back(b);
        br_due_q.push_back(edge_count + 2);
    endtask

    function automatic int pending();
        return wb_q.size() + br_q.size();
    endfunction

    function automatic int check_field(input string name, input logic [31:0] expected,
                                       input logic [31:0] actual);
        if (actual === expected) begin
            return 0;
        end
        $display("error %0t %s expected %h actual %h", $time, name, expected, actual);
        return 1;
    endfunction

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // ------------------------------
    // compare at the falling edge
    // ------------------------------
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            if (wb_q.size() == 0 || wb_due_q[0] != edge_count) begin
                $display("error %0t: write-back with no instruction due on this edge", $time);
                wb_errors++;
            end else begin
                wb_errors += check_field("wb.id", wb_q[0].id, wb.id);
                wb_errors += check_field("wb.pc", wb_q[0].pc, wb.pc);
                wb_errors += check_field("wb.instr", wb_q[0].instr, wb.instr);
                wb_errors += check_field("wb.rd_en", wb_q[0].rd_en, wb.rd_en);
                wb_errors += check_field("wb.rd_idx", wb_q[0].rd_idx, wb.rd_idx);
                wb_errors += check_field("wb.rd_val", wb_q[0].rd_val, wb.rd_val);
                wb_q.delete(0);
                wb_due_q.delete(0);
            end
        end
        if (wb_due_q.size() != 0 && wb_due_q[0] <= edge_count) begin
            $display("error %0t: instruction at pc %h gave no write-back", $time, wb_q[0].pc);
            wb_errors++;
            wb_q.delete(0);
            wb_due_q.delete(0);
        end
        if (!reset && branch_valid) begin
            if (br_q.size() == 0 || br_due_q[0] != edge_count) begin
                $display("error %0t: branch_valid with no taken branch due on this edge", $time);
                branch_errors++;
            end else begin
                branch_errors += check_field("branch.id", br_q[0].id, branch.id);
                branch_errors += check_field("branch.pc", br_q[0].pc, branch.pc);
                branch_errors += check_field("branch.old_pc", br_q[0].old_pc, branch.old_pc);
                branch_errors += check_field("branch.instr", br_q[0].instr, branch.instr);
                br_q.delete(0);
                br_due_q.delete(0);
            end
        end
        if (br_due_q.size() != 0 && br_due_q[0] <= edge_count) begin
            $display("error %0t: taken branch at pc %h gave no redirect", $time, br_q[0].old_pc);
            branch_errors++;
            br_q.delete(0);
            br_due_q.delete(0);
        end
    end

endmodule

//--- bench/tb_exec.sv
`timescale 1ns/1ps

module tb_exec;

    localparam int unsigned SEED = 32'he984;
    localparam int NUM_INSTR     = 300;
    localparam int STIM_TIMEOUT  = 1500;
    localparam int DRAIN_TIMEOUT = 20;

    logic              clk, reset, s_valid, wb_valid, branch_valid;
    exec_pkg::issue_t  s_issue;
    exec_pkg::wb_t     wb, exp_wb;
    exec_pkg::branch_t branch, exp_branch;
    int                sent, cycles, other_errors, total_errors;

    exec_top u_dut (.*);
    exec_checker u_checker (.*);
    bind exec_top exec_assert u_assert (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // stimulus and reference
    // ------------------------------

    // random decoded instruction with about a quarter branches or jumps
    function automatic exec_pkg::issue_t make_issue();
        exec_pkg::issue_t s;
        int unsigned      pick;
        s              = '0;
        s.id           = exec_pkg::id_t'($urandom);
        s.pc           = $urandom & 32'hffff_fffc;
        s.instr        = $urandom;
        s.rd_en        = 1'b1;
        s.rd_idx       = exec_pkg::ridx_t'($urandom);
        s.rd_val       = $urandom;
        s.rs1_val      = $urandom;
        s.rs2_val      = $urandom;
        s.imm_en       = $urandom % 2;
        s.imm_val      = $urandom % 4096;
        s.imm_val[31:12] = {20{s.imm_val[11]}};
        // shift amounts of 0 and 31 show up often
        s.rs2_val[4:0] = ($urandom % 3 == 0) ? {5{s.rs2_val[5]}} : s.rs2_val[4:0];
        s.imm_val[4:0] = ($urandom % 3 == 0) ? {5{s.imm_val[11]}} : s.imm_val[4:0];
        s.rs2_val      = ($urandom % 5 == 0) ? s.rs1_val : s.rs2_val;
        s.op           = exec_pkg::alu_op_t'($urandom % 5);
        s.sub          = $urandom % 2;
        s.slt_unsigned = $urandom % 2;
        pick           = $urandom % 4;
        s.logic_mode   = exec_pkg::logic_mode_t'((pick == 1) ? 0 : pick);
        s.shift_left   = ($urandom % 3 == 0);
        s.shift_arith  = $urandom % 2;
        if ($urandom % 4 == 0) begin
            s.op          = exec_pkg::op_pass;
            s.branch      = 1'b1;
            s.branch_mode = exec_pkg::branch_mode_t'($urandom % 8);
            s.rd_en       = s.branch_mode == exec_pkg::br_jal
                         || s.branch_mode == exec_pkg::br_jalr;
            s.rd_val      = s.pc + 4;
            s.imm_en      = (s.branch_mode == exec_pkg::br_jalr);
            s.branch_pc   = $urandom & 32'hffff_fffe;
        end
        return s;
    endfunction

    // expected write-back and redirect from the RV32I rules
    function automatic bit exec_ref(input exec_pkg::issue_t s, output exec_pkg::wb_t w,
                                    output exec_pkg::branch_t b);
        exec_pkg::rval_t op2;
        exec_pkg::rval_t sra;
        logic            lt;
        logic            taken;
        op2 = s.imm_en ? s.imm_val : s.rs2_val;
        sra = $signed(s.rs1_val) >>> op2[4:0];
        lt  = s.slt_unsigned ? (s.rs1_val < op2) : ($signed(s.rs1_val) < $signed(op2));
        w   = {s.id, s.pc, s.instr, s.rd_en, s.rd_idx, s.rd_val};
        case (s.op)
            exec_pkg::op_add:   w.rd_val = s.sub ? s.rs1_val - op2 : s.rs1_val + op2;
            exec_pkg::op_slt:   w.rd_val = {31'b0, lt};
            exec_pkg::op_shift: w.rd_val = s.shift_left ? s.rs1_val << op2[4:0]
                                         : s.shift_arith ? sra : s.rs1_val >> op2[4:0];
            exec_pkg::op_logic: w.rd_val = (s.logic_mode == exec_pkg::lm_xor) ? s.rs1_val ^ op2
                                         : (s.logic_mode == exec_pkg::lm_or) ? s.rs1_val | op2
                                         : s.rs1_val & op2;
            default:            w.rd_val = s.rd_val;
        endcase
        // conditional branches compare rs1 with rs2
        case (s.branch_mode)
            exec_pkg::br_beq:  taken = (s.rs1_val == s.rs2_val);
            exec_pkg::br_bne:  taken = (s.rs1_val != s.rs2_val);
            exec_pkg::br_blt:  taken = ($signed(s.rs1_val) < $signed(s.rs2_val));
            exec_pkg::br_bge:  taken = ($signed(s.rs1_val) >= $signed(s.rs2_val));
            exec_pkg::br_bltu: taken = (s.rs1_val < s.rs2_val);
            exec_pkg::br_bgeu: taken = (s.rs1_val >= s.rs2_val);
            default:           taken = 1'b1;
        endcase
        b = {s.id, s.branch_pc, s.pc, s.instr};
        if (s.branch_mode == exec_pkg::br_jalr) begin
            b.pc = (s.rs1_val + op2) & 32'hffff_fffe;
        end
        return s.branch && taken;
    endfunction

    initial begin
        void'($urandom(SEED));
        reset        = 1'b1;
        s_valid      = 1'b0;
        s_issue      = '0;
        sent         = 0;
        other_errors = 0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        // runs of back-to-back issue broken by random idle cycles
        for (cycles = 0; sent < NUM_INSTR && cycles < STIM_TIMEOUT; cycles++) begin
            @(posedge clk);
            #1;
            s_valid = ($urandom % 4 != 0);
            if (s_valid) begin
                s_issue = make_issue();
                if (exec_ref(s_issue, exp_wb, exp_branch)) begin
                    u_checker.expect_branch(exp_branch);
                end
                u_checker.expect_wb(exp_wb);
                sent++;
            end
        end
        @(posedge clk);
        #1;
        s_valid = 1'b0;
        cycles  = 0;
        while (u_checker.pending() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (u_checker.pending() != 0 || sent != NUM_INSTR) begin
            $display("timeout: %0d of %0d instructions sent, %0d results never arrived",
                     sent, NUM_INSTR, u_checker.pending());
            other_errors++;
        end
        repeat (3) @(posedge clk);
        total_errors = u_checker.wb_errors + u_checker.branch_errors
                     + u_dut.u_assert.fail_count + other_errors;
        $display("errors: write-back %0d, branch %0d, assertion %0d, other %0d",
                 u_checker.wb_errors, u_checker.branch_errors,
                 u_dut.u_assert.fail_count, other_errors);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- build.f
source/exec_pkg.sv
source/exec_stage0.sv
source/exec_stage1.sv
source/exec_stage2.sv
source/exec_top.sv
bench/exec_assert.sv
bench/exec_checker.sv
bench/tb_exec.sv

//--- Bender.yml
package:
  name: rv32i_exec

sources:
  - source/exec_pkg.sv
  - source/exec_stage0.sv
  - source/exec_stage1.sv
  - source/exec_stage2.sv
  - source/exec_top.sv
  - target: test
    files:
      - bench/exec_assert.sv
      - bench/exec_checker.sv
      - bench/tb_exec.sv
